/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // ****************************************
    // Access size, from funct3[1:0].
    // ****************************************

    // Code 2'b11 has no name and always faults.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    // ****************************************
    // Request and response.
    // ****************************************

    typedef struct packed {
        logic        is_store;
        logic        is_unsigned;
        mem_size_t   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        fault;
        logic        is_store;
    } lsu_resp_t;

    // ****************************************
    // Internal commands.
    // ****************************************

    // Byte enables of zero mean no write.
    typedef struct packed {
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        fault;
    } ram_wr_t;

    // Held for one cycle next to the RAM read.
    typedef struct packed {
        logic       valid;
        logic       is_store;
        logic       fault;
        logic       is_unsigned;
        mem_size_t  size;
        logic [1:0] offset;
    } load_ctx_t;

endpackage

/* hdl/access_decoder.sv */
module access_decoder (
    input  lsu_pkg::lsu_req_t req,
    input  logic              req_valid,
    output lsu_pkg::ram_wr_t  wr
);

    logic [1:0]  offset;
    logic [3:0]  lane_be;
    logic [31:0] wdata_rep;
    logic        misaligned;
    logic        do_write;

    assign offset = req.addr[1:0];

    // Lane selection and store data replication.
    always_comb begin
        lane_be    = 4'b0000;
        wdata_rep  = req.wdata;
        misaligned = 1'b0;
        case (req.size)
            lsu_pkg::SIZE_BYTE: begin
                wdata_rep = {4{req.wdata[7:0]}};
                case (offset)
                    2'd0: lane_be = 4'b0001;
                    2'd1: lane_be = 4'b0010;
                    2'd2: lane_be = 4'b0100;
                    default: lane_be = 4'b1000;
                endcase
            end
            lsu_pkg::SIZE_HALF: begin
                wdata_rep = {2{req.wdata[15:0]}};
                case (offset)
                    2'd0: lane_be = 4'b0011;
                    2'd2: lane_be = 4'b1100;
                    default: misaligned = 1'b1;
                endcase
            end
            lsu_pkg::SIZE_WORD: begin
                if (offset == 2'd0) begin
                    lane_be = 4'b1111;
                end else begin
                    misaligned = 1'b1;
                end
            end
            default: begin
                misaligned = 1'b1;
            end
        endcase
    end

    // A faulting store must leave memory untouched.
    assign do_write = req_valid && req.is_store && !misaligned;

    always_comb begin
        wr.be    = do_write ? lane_be : 4'b0000;
        wr.wdata = wdata_rep;
        wr.fault = misaligned;
    end

endmodule

/* hdl/data_ram.sv */
module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic             clk,
    input  logic             req_valid,
    input  logic [31:0]      addr,
    input  lsu_pkg::ram_wr_t wr,
    output logic [31:0]      rdata
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Upper address bits wrap.
    assign idx = addr[IDX_W+1:2];

    // ****************************************
    // Byte-lane write.
    // ****************************************

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr.be[b]) begin
                mem[idx][8*b +: 8] <= wr.wdata[8*b +: 8];
            end
        end
    end

    // ****************************************
    // Registered read, old data on a collision.
    // ****************************************

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata <= mem[idx];
        end
    end

endmodule

/* hdl/load_extractor.sv */
module load_extractor (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    input  logic               fault,
    input  logic [31:0]        ram_rdata,
    output lsu_pkg::load_ctx_t ctx,
    output logic [31:0]        ldata
);

    logic [7:0]  lane8;
    logic [15:0] lane16;
    logic        sign_ext;

    // ****************************************
    // Context stage, in step with the RAM.
    // ****************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctx <= '0;
        end else begin
            ctx.valid       <= req_valid;
            ctx.is_store    <= req.is_store;
            ctx.fault       <= fault;
            ctx.is_unsigned <= req.is_unsigned;
            ctx.size        <= req.size;
            ctx.offset      <= req.addr[1:0];
        end
    end

    // ****************************************
    // Lane select and extension.
    // ****************************************

    assign sign_ext = ~ctx.is_unsigned;
    assign lane8    = ram_rdata[8*ctx.offset +: 8];
    assign lane16   = ctx.offset[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // Misaligned cases fall through here and are zeroed downstream.
    always_comb begin
        case (ctx.size)
            lsu_pkg::SIZE_BYTE: begin
                ldata = {{24{sign_ext & lane8[7]}}, lane8};
            end
            lsu_pkg::SIZE_HALF: begin
                ldata = {{16{sign_ext & lane16[15]}}, lane16};
            end
            default: begin
                ldata = ram_rdata;
            end
        endcase
    end

endmodule

/* hdl/lsu_resp.sv */
module lsu_resp (
    input  logic               clk,
    input  logic               arst_n,
    input  lsu_pkg::load_ctx_t ctx,
    input  logic [31:0]        ldata,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);

    lsu_pkg::lsu_resp_t resp_next;
    logic               good_load;

    // ****************************************
    // Merge of store and load results.
    // ****************************************

    assign good_load = !ctx.is_store && !ctx.fault;

    always_comb begin
        resp_next.is_store = ctx.is_store;
        resp_next.fault    = ctx.fault;
        // Stores and faults report zero data.
        resp_next.rdata    = good_load ? ldata : 32'd0;
    end

    // ****************************************
    // Output register.
    // ****************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= ctx.valid;
        end
    end

    // Holds the last result between responses.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp <= '0;
        end else if (ctx.valid) begin
            resp <= resp_next;
        end
    end

endmodule

/* hdl/lsu_top.sv */
module lsu_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);

    lsu_pkg::ram_wr_t   wr;
    lsu_pkg::load_ctx_t ctx;
    logic [31:0]        ram_rdata;
    logic [31:0]        ldata;

    // ****************************************
    // Request side.
    // ****************************************

    access_decoder i_access_decoder (
        .req       (req),
        .req_valid (req_valid),
        .wr        (wr)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_data_ram (
        .clk       (clk),
        .req_valid (req_valid),
        .addr      (req.addr),
        .wr        (wr),
        .rdata     (ram_rdata)
    );

    // ****************************************
    // Read side and response.
    // ****************************************

    load_extractor i_load_extractor (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .fault     (wr.fault),
        .ram_rdata (ram_rdata),
        .ctx       (ctx),
        .ldata     (ldata)
    );

    lsu_resp i_lsu_resp (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctx        (ctx),
        .ldata      (ldata),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

/* bench/lsu_checker.sv */
module lsu_checker #(
    parameter int RAM_WORDS = 256
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    input  logic               resp_valid,
    input  lsu_pkg::lsu_resp_t resp,
    output logic               failed,
    output logic               pending
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BYTES = RAM_WORDS * 4;

    typedef struct packed {
        logic        valid;
        logic        is_store;
        logic        fault;
        logic        known;
        logic [31:0] rdata;
    } expect_t;

    logic [7:0] model [BYTES];
    expect_t    stage1;
    expect_t    stage2;
    logic       error_seen = 1'b0;

    assign failed  = error_seen;
    assign pending = stage1.valid || stage2.valid;

    // Unwritten bytes stay unknown.
    initial begin
        for (int i = 0; i < BYTES; i++) begin
            model[i] = 'x;
        end
    end

    // ****************************************
    // Reference rules.
    // ****************************************

    function automatic logic bad_align(input logic [1:0] size, input logic [1:0] offset);
        case (size)
            2'b00: return 1'b0;
            2'b01: return offset[0];
            2'b10: return offset != 2'b00;
            default: return 1'b1;
        endcase
    endfunction

    // Updates the model and predicts the response of one request.
    task automatic accept(input lsu_pkg::lsu_req_t r, output expect_t e);
        logic [31:0] byte_addr;
        logic [31:0] value;
        logic        sign;
        int          base;
        int          nbytes;
        byte_addr  = r.addr & 32'(BYTES - 1);
        base       = int'(byte_addr);
        nbytes     = 1 << r.size;
        value      = '0;
        e          = '0;
        e.valid    = 1'b1;
        e.is_store = r.is_store;
        e.fault    = bad_align(r.size, r.addr[1:0]);
        e.known    = 1'b1;
        if (!e.fault && r.is_store) begin
            for (int i = 0; i < nbytes; i++) begin
                model[base + i] = r.wdata[8*i +: 8];
            end
        end else if (!e.fault) begin
            for (int i = 0; i < nbytes; i++) begin
                value[8*i +: 8] = model[base + i];
            end
            if (!r.is_unsigned && nbytes < 4) begin
                sign = value[8*nbytes-1];
                for (int k = 8 * nbytes; k < 32; k++) begin
                    value[k] = sign;
                end
            end
            e.known = !$isunknown(value);
            e.rdata = value;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
        error_seen = 1'b1;
    endtask

    // ****************************************
    // Response checks.
    // ****************************************

    always @(negedge clk) begin
        expect_t fresh;
        if (!arst_n) begin
            assert (resp_valid == 1'b0)
                else report_mismatch("resp_valid", 32'(resp_valid), 32'd0);
            assert (resp.rdata == 32'd0)
                else report_mismatch("resp.rdata", resp.rdata, 32'd0);
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            assert (resp_valid == stage2.valid)
                else report_mismatch("resp_valid", 32'(resp_valid), 32'(stage2.valid));
            if (stage2.valid) begin
                assert (resp.is_store == stage2.is_store)
                    else report_mismatch("resp.is_store", 32'(resp.is_store),
                                         32'(stage2.is_store));
                assert (resp.fault == stage2.fault)
                    else report_mismatch("resp.fault", 32'(resp.fault), 32'(stage2.fault));
                if (stage2.known) begin
                    assert (resp.rdata == stage2.rdata)
                        else report_mismatch("resp.rdata", resp.rdata, stage2.rdata);
                end
            end
            if (req_valid) begin
                accept(req, fresh);
            end else begin
                fresh = '0;
            end
            stage2 <= stage1;
            stage1 <= fresh;
        end
    end

endmodule

/* bench/lsu_tb.sv */
module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RAM_WORDS      = 64;
    localparam logic [31:0] SEED           = 32'hff79ab95;
    localparam int          RESET_CYCLES   = 8;
    localparam int          FILL_REQS      = RAM_WORDS;
    localparam int          SWEEP_REQS     = RAM_WORDS * 32;
    localparam int          FAULT_REQS     = RAM_WORDS * 10;
    localparam int          RAW_REQS       = RAM_WORDS * 2;
    localparam int          RAND_REQS      = 2000;
    localparam int          TOTAL_REQS     = FILL_REQS + SWEEP_REQS + FAULT_REQS
                                             + RAW_REQS + RAND_REQS;
    localparam int          TIMEOUT_CYCLES = TOTAL_REQS * 2 + RESET_CYCLES + 100;

    logic               clk;
    logic               arst_n;
    logic               req_valid;
    lsu_pkg::lsu_req_t  req;
    logic               resp_valid;
    lsu_pkg::lsu_resp_t resp;
    logic               check_failed;
    logic               check_pending;
    int                 cycles = 0;

    lsu_top #(
        .RAM_WORDS (RAM_WORDS)
    ) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    lsu_checker #(
        .RAM_WORDS (RAM_WORDS)
    ) i_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp),
        .failed     (check_failed),
        .pending    (check_pending)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ****************************************
    // Helpers.
    // ****************************************

    task automatic stop_with_failure(input string reason);
        if (reason.len() > 0) begin
            $display("%s", reason);
        end
        $display("tests failed");
        $fatal(1);
    endtask

    // Top bit set in one lane so signed loads extend ones.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[7:0] ^ 8'hc3, ~addr[7:0], addr[7:0] | 8'h80, addr[7:0] + 8'h11};
    endfunction

    task automatic send(input logic store, input logic [2:0] funct3,
                        input logic [31:0] addr, input logic [31:0] data);
        req_valid       <= 1'b1;
        req.is_store    <= store;
        req.is_unsigned <= funct3[2];
        req.size        <= lsu_pkg::mem_size_t'(funct3[1:0]);
        req.addr        <= addr;
        req.wdata       <= data;
        @(posedge clk);
    endtask

    task automatic idle(input int n);
        req_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // ****************************************
    // Test phases.
    // ****************************************

    task automatic fill_memory();
        for (int w = 0; w < RAM_WORDS; w++) begin
            send(1'b1, 3'b010, 32'(w * 4), fill_word(32'(w * 4)));
        end
    endtask

    // Every funct3 at every offset, illegal sizes included.
    task automatic sweep_loads();
        for (int w = 0; w < RAM_WORDS; w++) begin
            for (int f = 0; f < 8; f++) begin
                for (int off = 0; off < 4; off++) begin
                    send(1'b0, 3'(f), 32'(w * 4 + off), 32'd0);
                end
            end
        end
    endtask

    task automatic faulting_stores();
        logic [31:0] base;
        for (int w = 0; w < RAM_WORDS; w++) begin
            base = 32'(w * 4);
            send(1'b1, 3'b001, base + 32'd1, $urandom());
            send(1'b1, 3'b001, base + 32'd3, $urandom());
            for (int off = 1; off < 4; off++) begin
                send(1'b1, 3'b010, base + 32'(off), $urandom());
            end
            for (int off = 0; off < 4; off++) begin
                send(1'b1, 3'b011, base + 32'(off), $urandom());
            end
            send(1'b0, 3'b010, base, 32'd0);
        end
    endtask

    // Load on the very next cycle after a store to the same word.
    task automatic store_then_load();
        logic [2:0]  funct3;
        logic [31:0] offset;
        for (int w = 0; w < RAM_WORDS; w++) begin
            funct3 = 3'($urandom_range(0, 2));
            case (funct3)
                3'b000: offset = 32'($urandom_range(0, 3));
                3'b001: offset = 32'($urandom_range(0, 1) * 2);
                default: offset = 32'd0;
            endcase
            send(1'b1, funct3, 32'(w * 4) + offset, $urandom());
            send(1'b0, 3'b010, 32'(w * 4), 32'd0);
        end
    endtask

    task automatic random_traffic();
        for (int n = 0; n < RAND_REQS; n++) begin
            send($urandom_range(0, 1) == 1, 3'($urandom_range(0, 7)),
                 $urandom_range(0, RAM_WORDS * 4 - 1), $urandom());
            if ($urandom_range(0, 3) == 0) begin
                idle(1);
            end
        end
    endtask

    // ****************************************
    // Run control.
    // ****************************************

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles without finishing.", cycles));
        end
    end

    always @(posedge check_failed) begin
        stop_with_failure("");
    end

    initial begin
        void'($urandom(SEED));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        fill_memory();
        sweep_loads();
        faulting_stores();
        store_then_load();
        random_traffic();
        idle(1);
        while (check_pending) begin
            @(posedge clk);
        end
        if (check_failed) begin
            stop_with_failure("");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* vlog.f */
hdl/lsu_pkg.sv
hdl/access_decoder.sv
hdl/data_ram.sv
hdl/load_extractor.sv
hdl/lsu_resp.sv
hdl/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = lsu_tb
FILELIST = vlog.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
PASS_MSG = all tests passed
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
